// File: src/bn_pkg.sv
package bn_pkg;

	localparam int DATA_W = 32; // item value, A and B
	localparam int PRODUCT_W = 64; // full signed product
	localparam int CHN_N = 1024; // parameter memory depth
	localparam int CHN_W = 10; // channel number width
	localparam int FRAC_W = 5; // quantization precision field
	localparam int REG_ADDR_W = 16;
	localparam int CFG_SEL_BIT = 15; // set selects the config register
	localparam int MUL_STAGES = 3; // multiplier register stages

	// one item in or out of the unit
	typedef struct packed {
		logic [CHN_W-1:0] chn; // output channel number
		logic [DATA_W-1:0] val; // signed value
	} bn_item_t;

	// live configuration seen by the datapath
	typedef struct packed {
		logic [FRAC_W-1:0] frac; // fixed point precision
		logic a_eq_1; // A taken as one
		logic b_eq_0; // B taken as zero
	} bn_cfg_t;

	// one parameter memory word
	typedef struct packed {
		logic [DATA_W-1:0] b; // upper half
		logic [DATA_W-1:0] a; // lower half
	} bn_param_t;

	// config register layout of a write word from the msb down
	typedef struct packed {
		logic [DATA_W-FRAC_W-3:0] rsvd; // 25 reserved bits
		logic b_eq_0;
		logic a_eq_1;
		logic [FRAC_W-1:0] frac; // bits 4..0
	} bn_cfg_word_t;

	// same write word as raw A/B data or as config fields
	typedef union packed {
		logic [DATA_W-1:0] raw;
		bn_cfg_word_t cfg;
	} bn_wdata_u;

endpackage

// File: src/bn_regs.sv
`timescale 1ns/1ps

module bn_regs (
	input  logic mul_bn_clk,
	input  logic rst_i,
	input  logic reg_wr_i, // one-cycle write strobe
	input  logic [bn_pkg::REG_ADDR_W-1:0] reg_addr_i,
	input  bn_pkg::bn_wdata_u reg_wdata_i,
	output bn_pkg::bn_cfg_t cfg_o,
	output logic [1:0] param_wr_o, // {B half, A half}
	output logic [bn_pkg::CHN_W-1:0] param_wr_chn_o,
	output logic [bn_pkg::DATA_W-1:0] param_wr_data_o
);
	import bn_pkg::*;

	logic cfg_hit;
	logic param_hit;

	assign cfg_hit = reg_wr_i && reg_addr_i[CFG_SEL_BIT];
	// channel addresses beyond the memory are dropped
	assign param_hit = reg_wr_i && !reg_addr_i[CFG_SEL_BIT]
		&& (reg_addr_i[CFG_SEL_BIT-1:CHN_W+1] == '0);

	always_ff @(posedge mul_bn_clk)
	begin
		if (rst_i)
		begin
			cfg_o <= '0;
		end
		else if (cfg_hit)
		begin
			cfg_o.frac <= reg_wdata_i.cfg.frac;
			cfg_o.a_eq_1 <= reg_wdata_i.cfg.a_eq_1;
			cfg_o.b_eq_0 <= reg_wdata_i.cfg.b_eq_0;
		end
	end

	always_ff @(posedge mul_bn_clk)
	begin
		if (rst_i)
			param_wr_o <= 2'b00;
		else
			param_wr_o <= {param_hit & reg_addr_i[0], param_hit & ~reg_addr_i[0]}; // bit 0 picks B
	end

	always_ff @(posedge mul_bn_clk)
	begin
		if (param_hit)
		begin
			param_wr_chn_o <= reg_addr_i[CHN_W:1]; // channel in bits 10..1
			param_wr_data_o <= reg_wdata_i.raw;
		end
	end

endmodule

// File: src/bn_param_mem.sv
`timescale 1ns/1ps

module bn_param_mem (
	input  logic mul_bn_clk,
	input  logic [1:0] wr_i, // {B half, A half}
	input  logic [bn_pkg::CHN_W-1:0] wr_chn_i,
	input  logic [bn_pkg::DATA_W-1:0] wr_data_i,
	input  logic rd_i,
	input  logic [bn_pkg::CHN_W-1:0] rd_chn_i,
	output bn_pkg::bn_param_t rd_param_o
);
	import bn_pkg::*;

	bn_param_t mem [CHN_N]; // one {B, A} word per channel

	// halves are written independently
	always_ff @(posedge mul_bn_clk)
	begin
		if (wr_i[0])
			mem[wr_chn_i].a <= wr_data_i;
		if (wr_i[1])
			mem[wr_chn_i].b <= wr_data_i;
	end

	// registered read that holds while idle
	always_ff @(posedge mul_bn_clk)
	begin
		if (rd_i)
			rd_param_o <= mem[rd_chn_i];
	end

endmodule

// File: src/bn_mul_pipe.sv
`timescale 1ns/1ps

module bn_mul_pipe (
	input  logic mul_bn_clk,
	input  logic [bn_pkg::MUL_STAGES-1:0] ce_i, // one enable per stage
	input  logic signed [bn_pkg::DATA_W-1:0] op_a_i,
	input  logic signed [bn_pkg::DATA_W-1:0] op_b_i,
	output logic signed [bn_pkg::PRODUCT_W-1:0] res_o
);
	import bn_pkg::*;

	logic signed [PRODUCT_W-1:0] stage_r [MUL_STAGES];

	// product register
	always_ff @(posedge mul_bn_clk)
	begin
		if (ce_i[0])
			stage_r[0] <= op_a_i * op_b_i;
	end

	// idle delay registers hold their value
	always_ff @(posedge mul_bn_clk)
	begin
		for (int s = 1; s < MUL_STAGES; s++)
		begin
			if (ce_i[s])
				stage_r[s] <= stage_r[s-1];
		end
	end

	assign res_o = stage_r[MUL_STAGES-1];

endmodule

// File: src/bn_datapath.sv
`timescale 1ns/1ps

module bn_datapath (
	input  logic mul_bn_clk,
	input  logic rst_i,
	input  bn_pkg::bn_cfg_t cfg_i,
	input  logic item_valid_i,
	input  bn_pkg::bn_item_t item_i,
	output logic param_rd_o,
	output logic [bn_pkg::CHN_W-1:0] param_rd_chn_o,
	input  bn_pkg::bn_param_t param_i,
	output logic res_valid_o,
	output bn_pkg::bn_item_t res_o
);
	import bn_pkg::*;

	// channel and B travelling beside the product
	typedef struct packed {
		logic [CHN_W-1:0] chn;
		logic [DATA_W-1:0] b;
	} side_t;

	logic [MUL_STAGES+1:0] vld_r; // 0 input, 1 param read, then mul stages
	bn_item_t in_item_r;
	bn_item_t rd_item_r; // item whose parameters are on param_i
	side_t side_r [MUL_STAGES];
	logic [MUL_STAGES-1:0] mul_ce;
	logic signed [DATA_W-1:0] op_a;
	logic signed [PRODUCT_W-1:0] mul_res;
	logic [FRAC_W-1:0] shift;
	logic [DATA_W-1:0] scaled;
	logic [DATA_W-1:0] add_b;

	always_ff @(posedge mul_bn_clk)
	begin
		if (rst_i)
			vld_r <= '0;
		else
			vld_r <= {vld_r[MUL_STAGES:0], item_valid_i};
	end

	always_ff @(posedge mul_bn_clk)
	begin
		if (item_valid_i)
			in_item_r <= item_i;
		if (vld_r[0])
			rd_item_r <= in_item_r;
	end

	assign param_rd_o = vld_r[0];
	assign param_rd_chn_o = in_item_r.chn;

	assign mul_ce = vld_r[MUL_STAGES:1]; // valid entering each stage
	assign op_a = cfg_i.a_eq_1 ? DATA_W'(1) : param_i.a;

	bn_mul_pipe mul_u (
		.mul_bn_clk(mul_bn_clk),
		.ce_i(mul_ce),
		.op_a_i(op_a),
		.op_b_i(rd_item_r.val),
		.res_o(mul_res)
	);

	always_ff @(posedge mul_bn_clk)
	begin
		if (mul_ce[0])
		begin
			side_r[0].chn <= rd_item_r.chn;
			side_r[0].b <= param_i.b;
		end
		for (int s = 1; s < MUL_STAGES; s++)
		begin
			if (mul_ce[s])
				side_r[s] <= side_r[s-1];
		end
	end

	assign shift = cfg_i.a_eq_1 ? '0 : cfg_i.frac; // no scaling when A is one
	assign scaled = DATA_W'(mul_res >>> shift); // low word of the shifted product
	assign add_b = cfg_i.b_eq_0 ? '0 : side_r[MUL_STAGES-1].b;

	always_ff @(posedge mul_bn_clk)
	begin
		if (rst_i)
			res_valid_o <= 1'b0;
		else
			res_valid_o <= vld_r[MUL_STAGES+1];
	end

	always_ff @(posedge mul_bn_clk)
	begin
		if (vld_r[MUL_STAGES+1])
		begin
			res_o.chn <= side_r[MUL_STAGES-1].chn;
			res_o.val <= scaled + add_b; // wraps
		end
	end

endmodule

// File: src/bn_unit.sv
`timescale 1ns/1ps

module bn_unit (
	input  logic mul_bn_clk,
	input  logic rst_i,
	input  logic reg_wr_i,
	input  logic [bn_pkg::REG_ADDR_W-1:0] reg_addr_i,
	input  bn_pkg::bn_wdata_u reg_wdata_i,
	input  logic item_valid_i,
	input  bn_pkg::bn_item_t item_i,
	output logic res_valid_o,
	output bn_pkg::bn_item_t res_o
);
	import bn_pkg::*;

	bn_cfg_t cfg;
	logic [1:0] param_wr; // half write enables
	logic [CHN_W-1:0] param_wr_chn;
	logic [DATA_W-1:0] param_wr_data;
	logic param_rd;
	logic [CHN_W-1:0] param_rd_chn;
	bn_param_t param_rd_data;

	bn_regs regs_u (
		.mul_bn_clk(mul_bn_clk),
		.rst_i(rst_i),
		.reg_wr_i(reg_wr_i),
		.reg_addr_i(reg_addr_i),
		.reg_wdata_i(reg_wdata_i),
		.cfg_o(cfg),
		.param_wr_o(param_wr),
		.param_wr_chn_o(param_wr_chn),
		.param_wr_data_o(param_wr_data)
	);

	bn_param_mem param_mem_u (
		.mul_bn_clk(mul_bn_clk),
		.wr_i(param_wr),
		.wr_chn_i(param_wr_chn),
		.wr_data_i(param_wr_data),
		.rd_i(param_rd),
		.rd_chn_i(param_rd_chn),
		.rd_param_o(param_rd_data)
	);

	bn_datapath datapath_u (
		.mul_bn_clk(mul_bn_clk),
		.rst_i(rst_i),
		.cfg_i(cfg),
		.item_valid_i(item_valid_i),
		.item_i(item_i),
		.param_rd_o(param_rd),
		.param_rd_chn_o(param_rd_chn),
		.param_i(param_rd_data),
		.res_valid_o(res_valid_o),
		.res_o(res_o)
	);

endmodule

// File: sim/tb_bn_unit.sv
`timescale 1ns/1ps

module tb_bn_unit;
	import bn_pkg::*;

	localparam int RAND_ITEMS = 300;
	localparam int FLAG_ITEMS = 100;
	localparam int REWRITE_ITEMS = 50;
	localparam int LATENCY_CYC = 5; // strobe edge to result edge
	// about 700 items plus register writes and drains with margin
	localparam int TIMEOUT_CYC = 4000;

	logic mul_bn_clk;
	logic rst_i;
	logic reg_wr_i;
	logic [REG_ADDR_W-1:0] reg_addr_i;
	bn_wdata_u reg_wdata_i;
	logic item_valid_i;
	bn_item_t item_i;
	logic res_valid_o;
	bn_item_t res_o;

	integer seed;
	int cycle_cnt;

	// shadow of what was written into the unit
	logic [DATA_W-1:0] sh_a [CHN_N];
	logic [DATA_W-1:0] sh_b [CHN_N];
	logic [FRAC_W-1:0] sh_frac;
	logic sh_a_eq_1;
	logic sh_b_eq_0;

	bn_item_t exp_q [$]; // expected results in issue order
	int issue_q [$]; // cycle each item was driven

	bn_unit bn_unit_i (
		.mul_bn_clk(mul_bn_clk),
		.rst_i(rst_i),
		.reg_wr_i(reg_wr_i),
		.reg_addr_i(reg_addr_i),
		.reg_wdata_i(reg_wdata_i),
		.item_valid_i(item_valid_i),
		.item_i(item_i),
		.res_valid_o(res_valid_o),
		.res_o(res_o)
	);

	always #50 mul_bn_clk = ~mul_bn_clk;

	always @(posedge mul_bn_clk)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYC)
		begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	end

	// A*x shifted by the precision, low word kept, plus B
	function automatic logic [DATA_W-1:0] bn_ref(input logic signed [DATA_W-1:0] x,
		input logic signed [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
		input logic [FRAC_W-1:0] frac, input logic a_eq_1, input logic b_eq_0);
		logic signed [DATA_W-1:0] scale;
		logic signed [PRODUCT_W-1:0] prod;
		logic signed [PRODUCT_W-1:0] shifted;
		logic [FRAC_W-1:0] sh;
		logic [DATA_W-1:0] offs;
		scale = a_eq_1 ? 32'sd1 : a;
		sh = a_eq_1 ? '0 : frac;
		prod = x * scale;
		shifted = prod >>> sh;
		offs = b_eq_0 ? '0 : b;
		return shifted[DATA_W-1:0] + offs;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s: got %h expected %h", name, got, exp);
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n)
		begin
			@(negedge mul_bn_clk);
			item_valid_i = 1'b0;
			reg_wr_i = 1'b0;
		end
	endtask

	task automatic write_reg(input logic [REG_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
		@(negedge mul_bn_clk);
		item_valid_i = 1'b0;
		reg_wr_i = 1'b1;
		reg_addr_i = addr;
		reg_wdata_i.raw = data;
		@(negedge mul_bn_clk);
		reg_wr_i = 1'b0;
	endtask

	// sel 0 writes A, sel 1 writes B
	task automatic write_param_half(input logic [CHN_W-1:0] chn, input logic sel,
		input logic [DATA_W-1:0] data);
		logic [REG_ADDR_W-1:0] addr;
		addr = '0;
		addr[CHN_W:1] = chn;
		addr[0] = sel;
		write_reg(addr, data);
		if (sel)
			sh_b[chn] = data;
		else
			sh_a[chn] = data;
	endtask

	task automatic write_param(input logic [CHN_W-1:0] chn, input logic [DATA_W-1:0] a,
		input logic [DATA_W-1:0] b);
		write_param_half(chn, 1'b0, a);
		write_param_half(chn, 1'b1, b);
	endtask

	task automatic write_cfg(input logic [FRAC_W-1:0] frac, input logic a_eq_1,
		input logic b_eq_0);
		bn_wdata_u w;
		logic [REG_ADDR_W-1:0] addr;
		w.raw = '0;
		w.cfg.frac = frac;
		w.cfg.a_eq_1 = a_eq_1;
		w.cfg.b_eq_0 = b_eq_0;
		addr = '0;
		addr[CFG_SEL_BIT] = 1'b1;
		write_reg(addr, w.raw);
		sh_frac = frac;
		sh_a_eq_1 = a_eq_1;
		sh_b_eq_0 = b_eq_0;
		idle_cycles(2); // let the new setting settle
	endtask

	task automatic send_item(input logic [CHN_W-1:0] chn, input logic [DATA_W-1:0] val);
		bn_item_t exp;
		@(negedge mul_bn_clk);
		reg_wr_i = 1'b0;
		item_valid_i = 1'b1;
		item_i.chn = chn;
		item_i.val = val;
		exp.chn = chn;
		exp.val = bn_ref(val, sh_a[chn], sh_b[chn], sh_frac, sh_a_eq_1, sh_b_eq_0);
		exp_q.push_back(exp);
		issue_q.push_back(cycle_cnt);
	endtask

	// wait for the results in flight, bounded by the latency
	task automatic drain();
		int waited;
		idle_cycles(1);
		waited = 0;
		while (exp_q.size() != 0 && waited < LATENCY_CYC + 2)
		begin
			@(negedge mul_bn_clk);
			waited++;
		end
		idle_cycles(2);
	endtask

	task automatic send_random(input int n, input logic [CHN_W-1:0] chn_mask);
		logic [31:0] r;
		logic [31:0] v;
		repeat (n)
		begin
			r = $random(seed);
			v = $random(seed);
			send_item(r[CHN_W-1:0] & chn_mask, v);
		end
	endtask

	// scoreboard compare on each result
	always @(negedge mul_bn_clk)
	begin
		bn_item_t exp;
		int issued;
		if (!rst_i && res_valid_o)
		begin
			if (exp_q.size() == 0)
			begin
				$display("a result arrived on channel %0d with no item pending", res_o.chn);
				$display("SOME TESTS FAILED");
				$fatal(1);
			end
			else
			begin
				exp = exp_q.pop_front();
				issued = issue_q.pop_front();
				check_value("res_o.chn", 64'(res_o.chn), 64'(exp.chn));
				check_value("res_o.val", 64'(res_o.val), 64'(exp.val));
				check_value("latency", 64'(cycle_cnt - issued - 1), 64'(LATENCY_CYC));
			end
		end
	end

	initial
	begin
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		seed = 25087;
		cycle_cnt = 0;
		mul_bn_clk = 1'b0;
		rst_i = 1'b1;
		reg_wr_i = 1'b0;
		reg_addr_i = '0;
		reg_wdata_i.raw = '0;
		item_valid_i = 1'b0;
		item_i = '0;
		sh_frac = '0;
		sh_a_eq_1 = 1'b0;
		sh_b_eq_0 = 1'b0;
		repeat (10) @(posedge mul_bn_clk);
		@(negedge mul_bn_clk);
		rst_i = 1'b0;

		// quiet output after reset
		repeat (20)
		begin
			@(negedge mul_bn_clk);
			check_value("res_valid_o", 64'(res_valid_o), 64'd0);
		end

		// single isolated items at precision 0
		write_cfg(5'd0, 1'b0, 1'b0);
		write_param(10'd5, 32'hffff_fffd, 32'd1000);
		idle_cycles(3);
		send_item(10'd5, 32'd12345);
		drain();
		send_item(10'd5, 32'h8000_0001);
		drain();

		// random parameters on 16 channels and back-to-back items
		for (int c = 0; c < 16; c++)
		begin
			a = $random(seed);
			b = $random(seed);
			write_param(10'(c), a, b);
		end
		r = $random(seed);
		write_cfg(r[FRAC_W-1:0], 1'b0, 1'b0);
		send_random(RAND_ITEMS, 10'h00f);
		drain();

		// A taken as one so the precision is ignored
		write_cfg(5'd12, 1'b1, 1'b0);
		send_random(FLAG_ITEMS, 10'h00f);
		drain();

		// B taken as zero, then both flags
		write_cfg(5'd7, 1'b0, 1'b1);
		send_random(FLAG_ITEMS, 10'h00f);
		drain();
		write_cfg(5'd7, 1'b1, 1'b1);
		send_random(FLAG_ITEMS, 10'h00f);
		drain();

		// rewrite only A of channel 3 and keep its B
		write_cfg(5'd4, 1'b0, 1'b0);
		send_random(REWRITE_ITEMS, 10'h003);
		drain();
		a = $random(seed);
		write_param_half(10'd3, 1'b0, a);
		idle_cycles(3);
		repeat (REWRITE_ITEMS)
		begin
			r = $random(seed);
			send_item(10'd3, r);
		end
		drain();

		if (exp_q.size() != 0)
		begin
			$display("%0d results never arrived", exp_q.size());
			$display("SOME TESTS FAILED");
			$fatal(1);
		end
		else
		begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

// File: files.f
src/bn_pkg.sv
src/bn_regs.sv
src/bn_param_mem.sv
src/bn_mul_pipe.sv
src/bn_datapath.sv
src/bn_unit.sv
sim/tb_bn_unit.sv

// File: Makefile
TOP = tb_bn_unit

.PHONY: all lint clean

all:
	verilator --binary -j 0 --top-module $(TOP) -f files.f -o sim_bn
	@out="$$(./obj_dir/sim_bn)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir
